// File: src/fifo_defines.svh
`ifndef FIFO_DEFINES_SVH
`define FIFO_DEFINES_SVH

// Width of one stored word
`define FIFO_DWIDTH 32

// Number of entries, any value from 1 upwards
`define FIFO_DEPTH 16

// Index width into the storage array
// A single entry still gets one bit
`define FIFO_AWIDTH ((`FIFO_DEPTH == 1) ? 1 : $clog2(`FIFO_DEPTH))

`endif

// File: src/fifo_pkg.sv
`default_nettype none

`include "fifo_defines.svh"

package fifo_pkg;

    // One stored word
    typedef logic [`FIFO_DWIDTH-1:0] fifo_data_t;

    // Read or write index into the array
    typedef logic [`FIFO_AWIDTH-1:0] fifo_ptr_t;

    // Entry count, one bit wider so it can hold the depth itself
    typedef logic [`FIFO_AWIDTH:0] fifo_count_t;

endpackage

`default_nettype wire

// File: src/fifo_ptr.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defines.svh"

module fifo_ptr
#(
    parameter int DEPTH = `FIFO_DEPTH
)
(
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 advance,
    output fifo_pkg::fifo_ptr_t index
);

    localparam int PTR_W = $bits(fifo_pkg::fifo_ptr_t);

    // Natural overflow already wraps a power-of-two depth
    localparam bit POW2 = (DEPTH == (1 << PTR_W));

    localparam fifo_pkg::fifo_ptr_t LAST = fifo_pkg::fifo_ptr_t'(DEPTH - 1);

    fifo_pkg::fifo_ptr_t index_p1;

    generate
        if (POW2)
        begin : g_pow2
            assign index_p1 = index + 1'b1;
        end
        else
        begin : g_wrap
            // Explicit wrap at the last entry
            assign index_p1 = (index == LAST) ? '0 : index + 1'b1;
        end
    endgenerate

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            index <= '0;
        end
        else if (advance)
        begin
            index <= index_p1;
        end
    end

endmodule

`default_nettype wire

// File: src/edff_2d.sv
`timescale 1ns/1ps
`default_nettype none

module edff_2d
#(
    parameter int REGISTER_WIDTH   = 32,
    parameter int NUM_OF_REGISTERS = 16
)
(
    input  wire                                        clk,
    input  wire                                        arst_n,
    input  wire  [NUM_OF_REGISTERS-1:0]                en,
    input  wire  [NUM_OF_REGISTERS*REGISTER_WIDTH-1:0] d,
    output logic [NUM_OF_REGISTERS*REGISTER_WIDTH-1:0] q
);

    // Word i sits at bits [i*REGISTER_WIDTH +: REGISTER_WIDTH] of d and q

    genvar i;

    generate
        for (i = 0; i < NUM_OF_REGISTERS; i++)
        begin : g_reg
            logic [REGISTER_WIDTH-1:0] word_d;
            logic [REGISTER_WIDTH-1:0] word_q;

            assign word_d = d[i*REGISTER_WIDTH +: REGISTER_WIDTH];

            always_ff @(posedge clk or negedge arst_n)
            begin
                if (!arst_n)
                begin
                    word_q <= '0;
                end
                else if (en[i])
                begin
                    word_q <= word_d;
                end
            end

            assign q[i*REGISTER_WIDTH +: REGISTER_WIDTH] = word_q;
        end
    endgenerate

endmodule

`default_nettype wire

// File: src/fifo_flopped.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defines.svh"

module fifo_flopped
(
    input  wire                  clk,
    input  wire                  arst_n,

    input  wire                  push,
    input  wire                  pop,
    input  wire fifo_pkg::fifo_data_t in_data,

    output fifo_pkg::fifo_data_t out_data,
    output logic                 full,
    output logic                 empty,
    output logic                 idle
);

    localparam int DWIDTH = `FIFO_DWIDTH;
    localparam int DEPTH  = `FIFO_DEPTH;

    localparam fifo_pkg::fifo_count_t COUNT_FULL = fifo_pkg::fifo_count_t'(DEPTH);

    // Pointers
    fifo_pkg::fifo_ptr_t wr_ptr;
    fifo_pkg::fifo_ptr_t rd_ptr;

    // Storage array, packed word by word
    logic [DEPTH-1:0]        wr_en;
    logic [DEPTH*DWIDTH-1:0] d_in;
    logic [DEPTH*DWIDTH-1:0] d_out;

    // Entry counter
    fifo_pkg::fifo_count_t count_q;
    fifo_pkg::fifo_count_t count_nxt;
    logic                  count_en;

    fifo_ptr
    #(
        .DEPTH (DEPTH)
    )
    wr_ptr_u
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .advance (push),
        .index   (wr_ptr)
    );

    fifo_ptr
    #(
        .DEPTH (DEPTH)
    )
    rd_ptr_u
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .advance (pop),
        .index   (rd_ptr)
    );

    // One-hot write enable at the write pointer
    always_comb
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            wr_en[i] = push && (wr_ptr == fifo_pkg::fifo_ptr_t'(i));
        end
    end

    // Every register sees the same input word
    assign d_in = {DEPTH{in_data}};

    edff_2d
    #(
        .REGISTER_WIDTH   (DWIDTH),
        .NUM_OF_REGISTERS (DEPTH)
    )
    data_regs_u
    (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (wr_en),
        .d      (d_in),
        .q      (d_out)
    );

    // Show-ahead read, oldest word is always on the output
    always_comb
    begin
        out_data = '0;
        for (int i = 0; i < DEPTH; i++)
        begin
            if (rd_ptr == fifo_pkg::fifo_ptr_t'(i))
            begin
                out_data = d_out[i*DWIDTH +: DWIDTH];
            end
        end
    end

    // Count only moves when exactly one strobe is high
    assign count_en = push ^ pop;

    always_comb
    begin
        if (push)
        begin
            count_nxt = count_q + 1'b1;
        end
        else
        begin
            count_nxt = count_q - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            count_q <= '0;
        end
        else if (count_en)
        begin
            count_q <= count_nxt;
        end
    end

    // Status flags
    assign empty = (count_q == '0);
    assign full  = (count_q == COUNT_FULL);

    // Nothing in flight besides the stored words
    assign idle = empty;

endmodule

`default_nettype wire

// File: verification/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
#(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 4
)
(
    output logic clk,
    output logic arst_n
);

    localparam int HALF = PERIOD / 2;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(HALF) clk = ~clk;
        end
    end

    // Release on a falling edge, away from the sampling edge
    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/fifo_flopped_props.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_flopped_props
(
    input wire                      clk,
    input wire                      arst_n,
    input wire                      push,
    input wire                      pop,
    input wire                      full,
    input wire                      empty,
    input wire                      idle,
    input wire fifo_pkg::fifo_ptr_t wr_ptr,
    input wire fifo_pkg::fifo_ptr_t rd_ptr
);

    // No overflow unless a pop frees the slot
    a_no_push_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        full |-> (!push || pop))
        else $error("push while full without a pop");

    a_no_pop_when_empty: assert property (@(posedge clk) disable iff (!arst_n)
        empty |-> !pop)
        else $error("pop while empty");

    // Pointers only meet when nothing or everything is stored
    a_flags_match_ptrs: assert property (@(posedge clk) disable iff (!arst_n)
        (full || empty) == (wr_ptr == rd_ptr))
        else $error("full/empty disagree with the pointers");

    a_idle_falls_on_push: assert property (@(posedge clk) disable iff (!arst_n)
        (idle && push) |=> !idle)
        else $error("idle still high after a push into an empty FIFO");

endmodule

bind fifo_flopped fifo_flopped_props props_u
(
    .clk    (clk),
    .arst_n (arst_n),
    .push   (push),
    .pop    (pop),
    .full   (full),
    .empty  (empty),
    .idle   (idle),
    .wr_ptr (wr_ptr),
    .rd_ptr (rd_ptr)
);

`default_nettype wire

// File: verification/tb_fifo_flopped.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defines.svh"

module tb_fifo_flopped;

    localparam int DEPTH = `FIFO_DEPTH;

    // Cycle budget per test
    localparam int LEN_RESET  = 8;
    localparam int LEN_FILL   = 2 * DEPTH + 2;
    localparam int LEN_WRAP   = 2000 + DEPTH;
    localparam int LEN_SIMUL  = 2 * DEPTH + 16;
    localparam int LEN_SHOW   = 6;
    localparam int MAX_CYCLES = LEN_RESET + LEN_FILL + LEN_WRAP + LEN_SIMUL + LEN_SHOW + 100;

    logic                 clk;
    logic                 arst_n;
    logic                 push;
    logic                 pop;
    fifo_pkg::fifo_data_t in_data;
    fifo_pkg::fifo_data_t out_data;
    logic                 full;
    logic                 empty;
    logic                 idle;

    // Reference model of the stored words, oldest first
    fifo_pkg::fifo_data_t model_q[$];

    int cycle_count;
    int error_count;
    int check_count;
    int test_errors;
    int test_checks;
    int tests_run;
    int tests_bad;

    tb_clkgen
    #(
        .PERIOD       (4),
        .RESET_CYCLES (4)
    )
    clkgen_u
    (
        .clk    (clk),
        .arst_n (arst_n)
    );

    fifo_flopped dut
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (push),
        .pop      (pop),
        .in_data  (in_data),
        .out_data (out_data),
        .full     (full),
        .empty    (empty),
        .idle     (idle)
    );

    function automatic fifo_pkg::fifo_data_t rand_word();
        return fifo_pkg::fifo_data_t'({$urandom, $urandom});
    endfunction

    task automatic compare_data(input fifo_pkg::fifo_data_t got,
                                input fifo_pkg::fifo_data_t exp);
        check_count++;
        test_checks++;
        if (got !== exp)
        begin
            $display("[ERROR] %0t: out_data is %h, expected %h", $time, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic compare_count_flags(input fifo_pkg::fifo_count_t cnt);
        logic exp_full;
        logic exp_empty;
        exp_full  = (cnt == fifo_pkg::fifo_count_t'(DEPTH));
        exp_empty = (cnt == '0);
        check_count++;
        test_checks++;
        if (full !== exp_full || empty !== exp_empty || idle !== exp_empty)
        begin
            $display("[ERROR] %0t: full/empty/idle are %b/%b/%b, expected %b/%b/%b at count %0d",
                     $time, full, empty, idle, exp_full, exp_empty, exp_empty, cnt);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_outputs();
        compare_count_flags(fifo_pkg::fifo_count_t'(model_q.size()));
        // Output word is only defined while something is stored
        if (model_q.size() != 0)
        begin
            compare_data(out_data, model_q[0]);
        end
    endtask

    // Called on a falling edge, returns on the next falling edge
    task automatic step(input logic do_push, input logic do_pop,
                        input fifo_pkg::fifo_data_t word);
        push    = do_push;
        pop     = do_pop;
        in_data = word;
        @(posedge clk);
        if (do_pop)
        begin
            void'(model_q.pop_front());
        end
        if (do_push)
        begin
            model_q.push_back(word);
        end
        @(negedge clk);
        push = 1'b0;
        pop  = 1'b0;
        check_outputs();
    endtask

    task automatic begin_test();
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0)
        begin
            tests_bad++;
        end
        $display("test %s: %0d checks, %0d mismatches", name, test_checks, test_errors);
    endtask

    task automatic drain();
        while (model_q.size() != 0)
        begin
            step(1'b0, 1'b1, '0);
        end
    endtask

    task automatic fill_to(input int level);
        while (model_q.size() < level)
        begin
            step(1'b1, 1'b0, rand_word());
        end
    endtask

    task automatic random_traffic(input int cycles);
        logic p;
        logic q;
        for (int i = 0; i < cycles; i++)
        begin
            p = ($urandom % 2) == 1;
            q = ($urandom % 2) == 1;
            if (model_q.size() == 0)
            begin
                q = 1'b0;
            end
            if (model_q.size() == DEPTH && !q)
            begin
                p = 1'b0;
            end
            step(p, q, rand_word());
        end
    endtask

    // Watchdog
    initial
    begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        fifo_pkg::fifo_data_t word;
        push        = 1'b0;
        pop         = 1'b0;
        in_data     = '0;
        error_count = 0;
        check_count = 0;
        tests_run   = 0;
        tests_bad   = 0;
        void'($urandom(32'h322f));

        begin_test();
        wait (arst_n === 1'b1);
        @(negedge clk);
        compare_count_flags('0);
        compare_data(out_data, '0);
        finish_test("reset");

        begin_test();
        fill_to(DEPTH);
        drain();
        finish_test("fill_drain");

        begin_test();
        random_traffic(2000);
        drain();
        finish_test("pointer_wrap");

        // Push and pop together at one entry, half full and full
        begin_test();
        fill_to(1);
        repeat (3) step(1'b1, 1'b1, rand_word());
        fill_to(DEPTH / 2);
        repeat (3) step(1'b1, 1'b1, rand_word());
        fill_to(DEPTH);
        repeat (3) step(1'b1, 1'b1, rand_word());
        drain();
        finish_test("push_pop");

        begin_test();
        word = rand_word();
        step(1'b1, 1'b0, word);
        compare_data(out_data, word);
        step(1'b0, 1'b0, '0);
        compare_data(out_data, word);
        step(1'b0, 1'b1, '0);
        finish_test("show_ahead");

        $display("tests: %0d, with errors: %0d, checks: %0d, mismatches: %0d",
                 tests_run, tests_bad, check_count, error_count);
        if (error_count == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fifo_flopped.f
+incdir+src
src/fifo_pkg.sv
src/fifo_ptr.sv
src/edff_2d.sv
src/fifo_flopped.sv
verification/tb_clkgen.sv
verification/fifo_flopped_props.sv
verification/tb_fifo_flopped.sv

// File: Makefile
# Verilator flow for the flopped FIFO

VERILATOR  ?= verilator
TOP        ?= tb_fifo_flopped
FILELIST   ?= fifo_flopped.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_MSG   := >>> PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result, not the simulator exit code
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
